/* Makefile */
# build and run the matrix multiplier regression with Verilator

TOP = tb_mat_mult

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): mat_mult.f logic/*.sv logic/*.svh bench/*.sv
	verilator --binary --timing --assert -f mat_mult.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing --assert -f mat_mult.f --top-module mat_mult_top

clean:
	rm -rf obj_dir

/* bench/tb_mat_mult.sv */
// random regression for mat_mult_top against a dot-product model
// inputs change on the falling edge, outputs are sampled there as well
// the model only takes loads that were presented while busy was low
// LCG stimulus, fixed seed, so every run is the same

`timescale 1ns/100ps
`default_nettype none

`include "mat_defs.svh"

module tb_mat_mult
   import mat_pkg::*;
();

   localparam int N   = `MAT_N;
   localparam int DW  = `MAT_DW;
   localparam int AW  = `MAT_AW;
   localparam int VW  = `MAT_VW;
   localparam int RW  = `MAT_RW;
   localparam int RVW = `MAT_RVW;
   // 4 directed runs plus 20 partial-reload passes
   localparam int NUM_PASSES  = 24;
   // full reload, run and slack per pass
   localparam int PASS_CYCLES = 2 * N + N + 10;
   localparam int WATCHDOG_NS = (NUM_PASSES * PASS_CYCLES + 100) * 100;
   // longest wait for all rows of one run
   localparam int RUN_LIMIT   = N + 12;

   logic            clk;
   logic            rst_n;
   logic            cmd_valid;
   cmd_e            cmd;
   logic [AW-1:0]   addr;
   logic [VW-1:0]   data;
   logic            busy;
   logic            result_valid;
   logic [AW-1:0]   result_row;
   logic [RVW-1:0]  result_data;

   // model copies, rows of A and columns of B
   logic [VW-1:0]   a_m [N];
   logic [VW-1:0]   b_m [N];
   logic [31:0]     rng;
   int              errors;
   int              checks;

   mat_mult_top mat_mult_top_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_valid    (cmd_valid),
      .cmd          (cmd),
      .addr         (addr),
      .data         (data),
      .busy         (busy),
      .result_valid (result_valid),
      .result_row   (result_row),
      .result_data  (result_data)
   );

   // 100 ns period
   always #50 clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   // one random row or column, upper LCG bits per element
   function automatic logic [VW-1:0] rand_vec();
      logic [VW-1:0] v;
      logic [31:0]   r;
      for (int k = 0; k < N; k++) begin
         r = next_rand();
         v[k*DW +: DW] = r[16 +: DW];
      end
      return v;
   endfunction

   // row r of C, element j is row r of A dotted with column j of B
   function automatic logic [RVW-1:0] model_row(input int r);
      logic [RVW-1:0] row;
      logic [RW-1:0]  acc;
      row = '0;
      for (int j = 0; j < N; j++) begin
         acc = '0;
         for (int k = 0; k < N; k++) begin
            acc = acc + RW'(a_m[r][k*DW +: DW]) * RW'(b_m[j][k*DW +: DW]);
         end
         row[j*RW +: RW] = acc;
      end
      return row;
   endfunction

   task automatic set_inputs(input logic v, input cmd_e c, input logic [AW-1:0] a,
                             input logic [VW-1:0] d);
      cmd_valid = v;
      cmd       = c;
      addr      = a;
      data      = d;
   endtask

   task automatic check_value(input string name, input logic [RVW-1:0] exp,
                              input logic [RVW-1:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   // random NOPs, nothing may start
   task automatic idle_cycles(input int n);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         r = next_rand();
         set_inputs(r[0], CMD_NOP, r[8 +: AW], rand_vec());
         @(negedge clk);
         check_value("busy", '0, RVW'(busy));
         check_value("result_valid", '0, RVW'(result_valid));
      end
      set_inputs(1'b0, CMD_NOP, '0, '0);
   endtask

   task automatic load_vector(input bit to_b, input int idx, input logic [VW-1:0] vec);
      // an ignored load would leave the model out of step
      check_value("busy", '0, RVW'(busy));
      set_inputs(1'b1, to_b ? CMD_LOAD_B : CMD_LOAD_A, AW'(idx), vec);
      @(negedge clk);
      if (to_b) begin
         b_m[idx] = vec;
      end else begin
         a_m[idx] = vec;
      end
      set_inputs(1'b0, CMD_NOP, '0, '0);
   endtask

   task automatic load_full(input bit max_val);
      for (int i = 0; i < N; i++) begin
         load_vector(1'b0, i, max_val ? '1 : rand_vec());
      end
      for (int i = 0; i < N; i++) begin
         load_vector(1'b1, i, max_val ? '1 : rand_vec());
      end
   endtask

   // run, then follow every cycle until the last row is out
   // disturb throws random commands at the busy DUT
   task automatic run_and_check(input bit disturb);
      logic [RVW-1:0] exp_rows [N];
      logic [31:0]    r;
      int             cyc;
      int             next_row;
      for (int i = 0; i < N; i++) begin
         exp_rows[i] = model_row(i);
      end
      set_inputs(1'b1, CMD_RUN, '0, '0);
      @(negedge clk);
      cyc      = 1;
      next_row = 0;
      while ((next_row < N) && (cyc <= RUN_LIMIT)) begin
         if (result_valid) begin
            // first row four cycles after the run command
            if (next_row == 0) begin
               assert (cyc == 4) else begin
                  errors++;
                  $display("FAILED t=%0t result_valid latency expected 4 got %0d",
                           $time, cyc);
               end
            end
            check_value("result_row", RVW'(next_row), RVW'(result_row));
            check_value("result_data", exp_rows[next_row], result_data);
            // busy falls with the last row
            check_value("busy", RVW'(next_row != N - 1), RVW'(busy));
            next_row++;
         end else begin
            assert (next_row == 0) else begin
               errors++;
               $display("result rows not on consecutive cycles, gap after row %0d at %0t",
                        next_row - 1, $time);
            end
            check_value("busy", RVW'(1'b1), RVW'(busy));
         end
         if (next_row < N) begin
            r = next_rand();
            if (disturb) begin
               set_inputs(r[0], cmd_e'(r[5:4]), r[8 +: AW], rand_vec());
            end else begin
               set_inputs(1'b0, CMD_NOP, '0, '0);
            end
            @(negedge clk);
            cyc++;
         end
      end
      assert (next_row == N) else begin
         errors++;
         $display("run timed out with only %0d of %0d result rows at %0t", next_row, N, $time);
      end
      set_inputs(1'b0, CMD_NOP, '0, '0);
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] r2;
      int          nload;
      clk    = 1'b0;
      rst_n  = 1'b0;
      rng    = 32'hb58d;
      errors = 0;
      checks = 0;
      set_inputs(1'b0, CMD_NOP, '0, '0);
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      idle_cycles(12);
      // random full matrices
      load_full(1'b0);
      run_and_check(1'b0);
      // largest elements, sums must not wrap
      load_full(1'b1);
      run_and_check(1'b0);
      // commands into a busy DUT are dropped, then a back-to-back rerun
      load_full(1'b0);
      run_and_check(1'b1);
      run_and_check(1'b0);
      // single rows or columns replaced between runs
      for (int p = 0; p < 20; p++) begin
         r     = next_rand();
         nload = 1 + (int'(r[1:0]) % 3);
         for (int i = 0; i < nload; i++) begin
            r2 = next_rand();
            load_vector(r2[0], int'(r2[8 +: AW]), rand_vec());
         end
         run_and_check((p % 2) == 1);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: simulation still running after %0d ns", WATCHDOG_NS);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* logic/mac_if.sv */
// operand and result bundle between the run sequencer and the MAC array
// res_valid is a one-cycle strobe with no back-pressure

`timescale 1ns/100ps
`default_nettype none

`include "mat_defs.svh"

interface mac_if;
   // row issue, registered alongside the A memory read
   logic                         issue;
   logic [`MAT_AW-1:0]           row_idx;
   // operands from the two memories
   logic [`MAT_VW-1:0]           a_row;
   logic [`MAT_N*`MAT_VW-1:0]    b_cols;
   // one full row of C
   logic                         res_valid;
   logic [`MAT_AW-1:0]           res_idx;
   logic [`MAT_RVW-1:0]          res_row;

   modport seq   (output issue, row_idx, input res_valid, res_idx);
   modport array (input issue, row_idx, a_row, b_cols,
                  output res_valid, res_idx, res_row);
endinterface

`default_nettype wire

/* logic/mac_row_array.sv */
// computes one row of C per cycle from one row of A and all columns of B
// two stages: N*N products, then N column sums at full width
// a_row must be valid in the same cycle as issue

`timescale 1ns/100ps
`default_nettype none

`include "mat_defs.svh"

module mac_row_array (
   input logic   clk,
   input logic   rst_n,
   mac_if.array  mac
);

   localparam int N  = `MAT_N;
   localparam int DW = `MAT_DW;
   localparam int VW = `MAT_VW;
   localparam int RW = `MAT_RW;
   localparam int PW = 2 * DW;

   // stage 1, indexed [column][element]
   logic [PW-1:0]      prod_q [N][N];
   logic               s1_valid;
   logic [`MAT_AW-1:0] s1_idx;
   // adder tree input for stage 2
   logic [RW-1:0]      col_sum [N];

   // products only load on an issued row
   always_ff @(posedge clk) begin
      if (mac.issue) begin
         for (int j = 0; j < N; j++) begin
            for (int k = 0; k < N; k++) begin
               // a element k times element k of column j
               prod_q[j][k] <= mac.a_row[k*DW +: DW] * mac.b_cols[j*VW + k*DW +: DW];
            end
         end
         s1_idx <= mac.row_idx;
      end
   end

   // column sums, widened before adding
   always_comb begin
      for (int j = 0; j < N; j++) begin
         col_sum[j] = '0;
         for (int k = 0; k < N; k++) begin
            col_sum[j] = col_sum[j] + RW'(prod_q[j][k]);
         end
      end
   end

   // stage 2 payload
   always_ff @(posedge clk) begin
      for (int j = 0; j < N; j++) begin
         mac.res_row[j*RW +: RW] <= col_sum[j];
      end
      mac.res_idx <= s1_idx;
   end

   // valid pipe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid      <= 1'b0;
         mac.res_valid <= 1'b0;
      end else begin
         s1_valid      <= mac.issue;
         mac.res_valid <= s1_valid;
      end
   end

   // each issued row comes out exactly two edges later, with its index
   a_res_latency : assert property (
      @(posedge clk) disable iff (!rst_n)
      (mac.res_valid == $past(mac.issue, 2)) &&
      (mac.res_valid -> (mac.res_idx == $past(mac.row_idx, 2)))
   ) else $error("mac_row_array: result does not follow issue by two cycles");

endmodule

`default_nettype wire

/* logic/mat_defs.svh */
// matrix size and width macros shared by every design file
// MAT_AW must stay equal to log2 of MAT_N, nothing derives it
// result width leaves room for N full-scale products, so no overflow

`ifndef MAT_DEFS_SVH
`define MAT_DEFS_SVH

// rows and columns of the square matrices
`define MAT_N 4
// unsigned element width
`define MAT_DW 8
// row and column index width
`define MAT_AW 2
// one row of A or one column of B, element 0 in the low bits
`define MAT_VW (`MAT_N * `MAT_DW)
// one element of C at full precision
`define MAT_RW (2 * `MAT_DW + `MAT_AW)
// one full row of C
`define MAT_RVW (`MAT_N * `MAT_RW)

`endif

/* logic/mat_mult_ctrl.sv */
// command decoder and run sequencer
// commands are taken only while busy is low, others are dropped
// busy drops as the last result row appears, so a run can follow at once

`timescale 1ns/100ps
`default_nettype none

`include "mat_defs.svh"

module mat_mult_ctrl
   import mat_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               cmd_valid,
   input  cmd_e               cmd,
   input  logic [`MAT_AW-1:0] addr,
   output logic [`MAT_AW-1:0] a_addr,
   output logic               a_we,
   output logic [`MAT_AW-1:0] b_addr,
   output logic               b_we,
   output logic               busy,
   mac_if.seq                 mac
);

   localparam logic [`MAT_AW-1:0] LAST_ROW = `MAT_AW'(`MAT_N - 1);

   ctrl_state_e        state;
   logic [`MAT_AW-1:0] row_cnt;
   logic               cmd_take;
   logic               last_done;
   logic               row_last;

   // last row of C leaving the array
   assign last_done = mac.res_valid && (mac.res_idx == LAST_ROW);
   assign row_last  = (row_cnt == LAST_ROW);

   // busy from run acceptance until the last result shows up
   assign busy = (state != ST_IDLE) && !((state == ST_DRAIN) && last_done);

   assign cmd_take = cmd_valid && !busy;

   // loads write at the accepting edge
   assign a_we = cmd_take && (cmd == CMD_LOAD_A);
   assign b_we = cmd_take && (cmd == CMD_LOAD_B);

   // A memory address is the row counter during a run
   assign a_addr = (state == ST_ISSUE) ? row_cnt : addr;
   assign b_addr = addr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         row_cnt   <= '0;
         mac.issue <= 1'b0;
      end else begin
         // issue lines up with the registered A row
         mac.issue <= (state == ST_ISSUE);
         case (state)
            ST_IDLE, ST_DRAIN: begin
               // drain can take a new run on its final cycle
               if (cmd_take && (cmd == CMD_RUN)) begin
                  state   <= ST_ISSUE;
                  row_cnt <= '0;
               end else if ((state == ST_DRAIN) && last_done) begin
                  state <= ST_IDLE;
               end
            end
            ST_ISSUE: begin
               // one row address per cycle
               row_cnt <= row_cnt + 1'b1;
               if (row_last) begin
                  state <= ST_DRAIN;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // row index rides with issue
   always_ff @(posedge clk) begin
      mac.row_idx <= row_cnt;
   end

   // no memory write while rows of a run are still in the pipeline
   a_no_write_busy : assert property (
      @(posedge clk) disable iff (!rst_n)
      (a_we || b_we) |->
         (!mac.issue && (!mac.res_valid || (mac.res_idx == LAST_ROW)))
   ) else $error("mat_mult_ctrl: memory write during a run");

   // issue pulses only inside a busy run
   a_issue_state : assert property (
      @(posedge clk) disable iff (!rst_n)
      mac.issue |-> busy
   ) else $error("mat_mult_ctrl: issue outside a run");

endmodule

`default_nettype wire

/* logic/mat_mult_top.sv */
// C = A x B for MAT_N square matrices of unsigned MAT_DW-bit elements
// load A by rows and B by columns, then CMD_RUN
// results stream out one row per cycle with no back-pressure
// capture every cycle where result_valid is high

`timescale 1ns/100ps
`default_nettype none

`include "mat_defs.svh"

module mat_mult_top
   import mat_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                cmd_valid,
   input  cmd_e                cmd,
   input  logic [`MAT_AW-1:0]  addr,
   input  logic [`MAT_VW-1:0]  data,
   output logic                busy,
   output logic                result_valid,
   output logic [`MAT_AW-1:0]  result_row,
   output logic [`MAT_RVW-1:0] result_data
);

   logic [`MAT_AW-1:0] a_addr;
   logic               a_we;
   logic [`MAT_AW-1:0] b_addr;
   logic               b_we;

   mac_if mac_bus ();

   mat_mult_ctrl ctrl_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .addr      (addr),
      .a_addr    (a_addr),
      .a_we      (a_we),
      .b_addr    (b_addr),
      .b_we      (b_we),
      .busy      (busy),
      .mac       (mac_bus.seq)
   );

   // rows of A, one read per address
   row_col_memory #(.ALL_ACCESS_OUTPUT(0)) a_mem (
      .clk          (clk),
      .address      (a_addr),
      .write_enable (a_we),
      .datain       (data),
      .dataout      (mac_bus.a_row)
   );

   // columns of B, all visible at once
   row_col_memory #(.ALL_ACCESS_OUTPUT(1)) b_mem (
      .clk          (clk),
      .address      (b_addr),
      .write_enable (b_we),
      .datain       (data),
      .dataout      (mac_bus.b_cols)
   );

   mac_row_array array_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .mac   (mac_bus.array)
   );

   assign result_valid = mac_bus.res_valid;
   assign result_row   = mac_bus.res_idx;
   assign result_data  = mac_bus.res_row;

endmodule

`default_nettype wire

/* logic/mat_pkg.sv */
// command and controller state types for the matrix multiplier
// encodings are fixed, the host drives cmd with these raw values

`default_nettype none

package mat_pkg;

   // host command opcodes
   typedef enum logic [1:0] {
      CMD_NOP    = 2'd0,
      CMD_LOAD_A = 2'd1,
      CMD_LOAD_B = 2'd2,
      CMD_RUN    = 2'd3
   } cmd_e;

   // run sequencer states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_ISSUE = 2'd1,
      ST_DRAIN = 2'd2
   } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/row_col_memory.sv */
// vector memory of MAT_N entries, MAT_VW bits each
// ALL_ACCESS_OUTPUT = 0: one registered entry per address, 1 cycle latency
// ALL_ACCESS_OUTPUT = 1: flop bank, all entries on dataout after the write edge
// contents are not reset

`timescale 1ns/100ps
`default_nettype none

`include "mat_defs.svh"

module row_col_memory #(
   parameter int ALL_ACCESS_OUTPUT = 0,
   localparam int OUT_W = (ALL_ACCESS_OUTPUT == 1) ? `MAT_N * `MAT_VW : `MAT_VW
) (
   input  logic              clk,
   input  logic [`MAT_AW-1:0] address,
   input  logic              write_enable,
   input  logic [`MAT_VW-1:0] datain,
   output logic [OUT_W-1:0]  dataout
);

   generate
      if (ALL_ACCESS_OUTPUT == 0) begin : g_row_read
         // plain array, lets synthesis infer a RAM
         logic [`MAT_VW-1:0] mem [`MAT_N];

         always_ff @(posedge clk) begin
            if (write_enable) begin
               mem[address] <= datain;
            end
         end

         // registered read of the addressed row
         // same-address write returns the old word
         always_ff @(posedge clk) begin
            dataout <= mem[address];
         end
      end else begin : g_all_access
         // every entry lives in dataout itself
         // one flop bank per entry, no read port
         always_ff @(posedge clk) begin
            for (int i = 0; i < `MAT_N; i++) begin
               if (write_enable && (address == `MAT_AW'(i))) begin
                  dataout[i*`MAT_VW +: `MAT_VW] <= datain;
               end
            end
         end
      end
   endgenerate

   // a write to an unknown address would smear X over the whole memory
   a_wr_addr_known : assert property (
      @(posedge clk) write_enable |-> !$isunknown(address)
   ) else $error("row_col_memory: write with unknown address");

endmodule

`default_nettype wire

/* mat_mult.f */
+incdir+logic
logic/mat_pkg.sv
logic/mac_if.sv
logic/row_col_memory.sv
logic/mac_row_array.sv
logic/mat_mult_ctrl.sv
logic/mat_mult_top.sv
bench/tb_mat_mult.sv
